// ==== build.f ====
source/rv_isa_pkg.sv
source/wb_bus_pkg.sv
source/wb_if.sv
source/bs_decode.sv
source/bs_ctrl.sv
source/bs_alu.sv
source/bs_regfile.sv
source/bs_mem_if.sv
source/wb_arbiter.sv
source/bs_cpu_top.sv
testbench/tb_bs_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the bit-serial cpu testbench with verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module tb_bs_cpu \
   -f build.f -o sim_bs_cpu

./obj_dir/sim_bs_cpu | tee sim.log

# the log decides pass or fail
if grep -qx "SIMULATION PASSED" sim.log; then
   exit 0
fi
exit 1

// ==== testbench/prog_trace.txt ====
# header: image word count, expected store count, halt address
# then image lines (byte address, word) and store lines (byte address, data), all hex
33 12 0000007c
# program: addi, add, sub, and, or, xor, slt, sltu, lui, lw, branches, jal
00000000 12300093
00000004 faa00113
00000008 002081b3
0000000c 20302023
00000010 402081b3
00000014 20302223
00000018 0020f1b3
0000001c 20302423
00000020 0020e1b3
00000024 20302623
00000028 0020c1b3
0000002c 20302823
00000030 001121b3
00000034 00113233
00000038 abcde2b7
0000003c 20302a23
00000040 20402c23
00000044 20502e23
00000048 10002303
0000004c 22602023
00000050 00208463
00000054 22102223
00000058 00209463
0000005c 22202423
00000060 00318463
00000064 22202623
00000068 00021463
0000006c 22302823
00000070 008003ef
00000074 22202a23
00000078 22702c23
0000007c 0000006f
# preloaded word for the load round trip
00000100 5a3c96e1
# expected stores in order
00000200 000000cd
00000204 00000179
00000208 00000122
0000020c ffffffab
00000210 fffffe89
00000214 00000001
00000218 00000000
0000021c abcde000
00000220 5a3c96e1
00000224 00000123
00000230 00000001
00000238 00000074

// ==== testbench/tb_bs_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bs_cpu;
   import wb_bus_pkg::*;

   localparam logic [31:0] RESET_PC = 32'd0;

   logic    clk = 1'b0;
   logic    i_rst_n;
   wb_dat_t i_wb_dat;
   logic    i_wb_ack;
   wb_adr_t o_wb_adr;
   wb_dat_t o_wb_dat;
   wb_sel_t o_wb_sel;
   logic    o_wb_we;
   logic    o_wb_cyc;
   logic    o_wb_stb;

   // word-addressed model of a 4 KiB memory
   logic [31:0] mem [0:1023];
   logic [31:0] exp_adr [$];
   logic [31:0] exp_dat [$];
   logic [31:0] halt_adr;
   int          n_image = 0;
   int          n_store = 0;
   bit          trace_ok = 1'b0;

   int errors     = 0;
   int tests      = 0;
   int failed     = 0;
   int cycles     = 0;
   int limit      = 0;
   int store_idx  = 0;
   int bus_cycles = 0;
   int hold_errs  = 0;
   int waits      = 0;
   int seed       = 0;
   int e0         = 0;
   bit in_cyc     = 1'b0;
   bit halted     = 1'b0;

   // request as seen when the bus cycle opened
   logic [31:0] held_adr;
   logic [31:0] held_dat;
   wb_sel_t     held_sel;
   logic        held_we;

   bs_cpu_top #(.RESET_PC(RESET_PC)) bs_cpu_top_inst (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_wb_dat (i_wb_dat),
      .i_wb_ack (i_wb_ack),
      .o_wb_adr (o_wb_adr),
      .o_wb_dat (o_wb_dat),
      .o_wb_sel (o_wb_sel),
      .o_wb_we  (o_wb_we),
      .o_wb_cyc (o_wb_cyc),
      .o_wb_stb (o_wb_stb)
   );

   always #4 clk = ~clk;

   task automatic check_val(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
      if (actual !== expected) begin
         $display("ERROR time %0t: %s is %h, expected %h", $time, name, actual, expected);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input bit ok);
      tests++;
      if (ok) begin
         $display("%s: pass", name);
      end else begin
         failed++;
         $display("%s: fail", name);
      end
   endtask

   task automatic read_trace();
      int          fd;
      int          n;
      int          got;
      int          i;
      string       line;
      logic [31:0] a;
      logic [31:0] d;
      // unloaded words read back as a pattern of their own address
      for (i = 0; i < 1024; i++) begin
         mem[i] = 32'hbad00000 ^ 32'(i << 2);
      end
      fd = $fopen("testbench/prog_trace.txt", "r");
      if (fd == 0) begin
         $display("trace file testbench/prog_trace.txt could not be opened");
         return;
      end
      n = 0;
      while (!$feof(fd)) begin
         line = "";
         got  = $fgets(line, fd);
         if (got == 0 || line.len() < 2 || line[0] == "#") begin
            continue;
         end
         if (n == 0) begin
            got = $sscanf(line, "%d %d %h", n_image, n_store, halt_adr);
         end else if (n <= n_image) begin
            got = $sscanf(line, "%h %h", a, d);
            mem[a[11:2]] = d;
         end else begin
            got = $sscanf(line, "%h %h", a, d);
            exp_adr.push_back(a);
            exp_dat.push_back(d);
         end
         n++;
      end
      $fclose(fd);
      trace_ok = (n == 1 + n_image + n_store) && (n_store > 0);
      if (!trace_ok) begin
         $display("trace file is incomplete, %0d data lines read", n);
      end
   endtask

   task automatic open_bus_cycle();
      int e;
      in_cyc   = 1'b1;
      waits    = int'($urandom % 4);
      held_adr = o_wb_adr;
      held_dat = o_wb_dat;
      held_sel = o_wb_sel;
      held_we  = o_wb_we;
      bus_cycles++;
      if (bus_cycles == 1) begin
         e = errors;
         check_val("o_wb_adr", o_wb_adr, RESET_PC);
         check_val("o_wb_we", 32'(o_wb_we), 32'h0);
         report_test("first request is a read at the reset pc", errors == e);
      end
   endtask

   task automatic check_bus_hold();
      int e;
      e = errors;
      check_val("o_wb_adr", o_wb_adr, held_adr);
      check_val("o_wb_dat", o_wb_dat, held_dat);
      check_val("o_wb_sel", 32'(o_wb_sel), 32'(held_sel));
      check_val("o_wb_we", 32'(o_wb_we), 32'(held_we));
      hold_errs += errors - e;
   endtask

   task automatic check_store();
      int e;
      e = errors;
      if (store_idx >= exp_adr.size()) begin
         $display("unexpected store of %h to address %h", o_wb_dat, o_wb_adr);
         errors++;
         report_test("store outside the expected list", 1'b0);
      end else begin
         check_val("o_wb_adr", o_wb_adr, exp_adr[store_idx]);
         check_val("o_wb_dat", o_wb_dat, exp_dat[store_idx]);
         check_val("o_wb_sel", 32'(o_wb_sel), 32'hf);
         report_test($sformatf("store %0d to %h", store_idx, exp_adr[store_idx]),
                     errors == e);
      end
      store_idx++;
   endtask

   task automatic serve_access();
      if (o_wb_adr[31:12] != 20'd0 || o_wb_adr[1:0] != 2'd0) begin
         $display("access to %h lies outside the memory model", o_wb_adr);
         errors++;
      end
      if (o_wb_we) begin
         mem[o_wb_adr[11:2]] = o_wb_dat;
         check_store();
      end else begin
         i_wb_dat = mem[o_wb_adr[11:2]];
         if (o_wb_adr == halt_adr) begin
            halted = 1'b1;
         end
      end
      i_wb_ack = 1'b1;
   endtask

   // slave model sampled and driven just after each rising edge
   always @(posedge clk) begin
      #1;
      cycles++;
      if (i_wb_ack) begin
         i_wb_ack = 1'b0;
         in_cyc   = 1'b0;
      end else if (in_cyc && !o_wb_cyc) begin
         $display("bus cycle at %h ended without an ack", held_adr);
         errors++;
         hold_errs++;
         in_cyc = 1'b0;
      end else if (o_wb_cyc) begin
         check_val("o_wb_stb", 32'(o_wb_stb), 32'h1);
         if (!in_cyc) begin
            open_bus_cycle();
         end else begin
            check_bus_hold();
         end
         if (waits == 0) begin
            serve_access();
         end else begin
            waits--;
         end
      end
   end

   initial begin
      i_rst_n  = 1'b0;
      i_wb_dat = '0;
      i_wb_ack = 1'b0;
      $timeformat(-9, 0, " ns", 0);
      seed = $urandom(32'h39eb);
      read_trace();
      // worst case per instruction, two bus phases with 3 waits each
      limit = (int'(halt_adr >> 2) + 1) * (70 + 2 * 3) * 2;

      repeat (2) @(posedge clk);
      #1;
      e0 = errors;
      check_val("o_wb_cyc", 32'(o_wb_cyc), 32'h0);
      report_test("reset state", errors == e0);
      i_rst_n = 1'b1;

      if (trace_ok) begin
         while (!halted && cycles < limit) begin
            @(posedge clk);
         end
      end
      if (!halted) begin
         $display("program did not reach its halt loop within %0d cycles", limit);
      end
      report_test("program completion", halted);
      report_test($sformatf("bus hold under wait states over %0d bus cycles", bus_cycles),
                  hold_errs == 0);
      e0 = errors;
      check_val("store count", 32'(store_idx), 32'(n_store));
      report_test("store count", errors == e0);

      $display("tests run %0d, failed %0d, errors %0d", tests, failed, errors);
      if (failed == 0 && errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/bs_cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bs_cpu_top #(
   parameter logic [31:0] RESET_PC = 32'd0
) (
   input  wire                  clk,
   input  wire                  i_rst_n,
   input  wb_bus_pkg::wb_dat_t  i_wb_dat,
   input  wire                  i_wb_ack,
   output wb_bus_pkg::wb_adr_t  o_wb_adr,
   output wb_bus_pkg::wb_dat_t  o_wb_dat,
   output wb_bus_pkg::wb_sel_t  o_wb_sel,
   output logic                 o_wb_we,
   output logic                 o_wb_cyc,
   output logic                 o_wb_stb
);
   import rv_isa_pkg::*;

   wb_if ibus ();
   wb_if dbus ();
   wb_if mbus ();

   logic       ctrl_en, jump, alu_init, rs_en, rd_en, mem_en, mem_we, fetch;
   logic       imm, rs1, rs2, op_b, rd, ctrl_rd, alu_rd, mem_rd;
   logic       cnt_done, cmp, mem_done;
   logic [4:0] rs1_addr, rs2_addr, rd_addr;
   alu_op_t    alu_op;
   rd_src_t    rd_src;
   opb_src_t   opb_src;

   assign op_b = (opb_src == OPB_SRC_RS2) ? rs2 : imm;

   always_comb begin
      case (rd_src)
         RD_SRC_CTRL: rd = ctrl_rd;
         RD_SRC_IMM:  rd = imm;
         RD_SRC_MEM:  rd = mem_rd;
         default:     rd = alu_rd;
      endcase
   end

   bs_decode bs_decode_inst (
      .clk(clk), .i_rst_n(i_rst_n), .i_insn(ibus.dat_r),
      .i_insn_vld(ibus.cyc & ibus.ack), .i_cnt_done(cnt_done), .i_cmp(cmp),
      .i_mem_done(mem_done), .o_ctrl_en(ctrl_en), .o_jump(jump), .o_alu_op(alu_op),
      .o_alu_init(alu_init), .o_rs_en(rs_en), .o_rd_en(rd_en), .o_rs1_addr(rs1_addr),
      .o_rs2_addr(rs2_addr), .o_rd_addr(rd_addr), .o_mem_en(mem_en), .o_mem_we(mem_we),
      .o_imm(imm), .o_rd_src(rd_src), .o_opb_src(opb_src), .o_fetch(fetch)
   );

   bs_ctrl #(.RESET_PC(RESET_PC)) bs_ctrl_inst (
      .clk(clk), .i_rst_n(i_rst_n), .i_en(ctrl_en), .i_jump(jump), .i_offset(imm),
      .i_fetch(fetch), .o_link_rd(ctrl_rd), .o_cnt_done(cnt_done), .ibus(ibus)
   );

   bs_alu bs_alu_inst (
      .clk(clk), .i_en(ctrl_en), .i_init(alu_init), .i_op(alu_op), .i_rs1(rs1),
      .i_op_b(op_b), .o_rd(alu_rd), .o_cmp(cmp)
   );

   bs_regfile bs_regfile_inst (
      .clk(clk), .i_rs_en(rs_en), .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
      .i_rd_en(rd_en), .i_rd_addr(rd_addr), .i_rd(rd), .o_rs1(rs1), .o_rs2(rs2)
   );

   bs_mem_if bs_mem_if_inst (
      .clk(clk), .i_rst_n(i_rst_n), .i_en(mem_en), .i_we(mem_we), .i_addr_bit(alu_rd),
      .i_rs2(rs2), .o_rd(mem_rd), .o_done(mem_done), .dbus(dbus)
   );

   wb_arbiter wb_arbiter_inst (
      .clk(clk), .i_rst_n(i_rst_n), .m0(dbus), .m1(ibus), .s(mbus)
   );

   assign o_wb_adr   = mbus.adr;
   assign o_wb_dat   = mbus.dat_w;
   assign o_wb_sel   = mbus.sel;
   assign o_wb_we    = mbus.we;
   assign o_wb_cyc   = mbus.cyc;
   assign o_wb_stb   = mbus.stb;
   assign mbus.dat_r = i_wb_dat;
   assign mbus.ack   = i_wb_ack;

endmodule

`default_nettype wire

// ==== source/wb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
   input  wire   clk,
   input  wire   i_rst_n,
   wb_if.slave   m0,
   wb_if.slave   m1,
   wb_if.master  s
);

   logic own_vld;
   logic own_m0;
   logic sel_m0;

   // an open cycle keeps its owner, else data master wins
   assign sel_m0 = own_vld ? own_m0 : m0.cyc;

   assign s.adr   = sel_m0 ? m0.adr   : m1.adr;
   assign s.dat_w = sel_m0 ? m0.dat_w : m1.dat_w;
   assign s.sel   = sel_m0 ? m0.sel   : m1.sel;
   assign s.we    = sel_m0 ? m0.we    : m1.we;
   assign s.cyc   = sel_m0 ? m0.cyc   : m1.cyc;
   assign s.stb   = sel_m0 ? m0.stb   : m1.stb;

   assign m0.dat_r = s.dat_r;
   assign m1.dat_r = s.dat_r;
   assign m0.ack   = sel_m0 & s.ack;
   assign m1.ack   = ~sel_m0 & s.ack;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         own_vld <= 1'b0;
         own_m0  <= 1'b0;
      end else if (s.cyc && !s.ack) begin
         own_vld <= 1'b1;
         own_m0  <= sel_m0;
      end else begin
         own_vld <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== source/bs_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

module bs_mem_if (
   input  wire    clk,
   input  wire    i_rst_n,
   input  wire    i_en,
   input  wire    i_we,
   input  wire    i_addr_bit,
   input  wire    i_rs2,
   output logic   o_rd,
   output logic   o_done,
   wb_if.master   dbus
);
   import wb_bus_pkg::*;

   wb_adr_t adr;
   wb_dat_t dat;
   logic    cyc;
   logic    we_r;

   assign o_rd   = dat[0];
   assign o_done = cyc & dbus.ack;

   // address pass when we is low, data pass in or out when high
   always_ff @(posedge clk) begin
      if (!cyc && !i_en) begin
         if (i_we) begin
            dat <= {i_rs2, dat[31:1]};
         end else begin
            adr <= {i_addr_bit, adr[31:1]};
         end
      end else if (o_done && !we_r) begin
         dat <= dbus.dat_r;
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         cyc  <= 1'b0;
         we_r <= 1'b0;
      end else if (cyc) begin
         if (dbus.ack) begin
            cyc <= 1'b0;
         end
      end else if (i_en) begin
         cyc  <= 1'b1;
         we_r <= i_we;
      end
   end

   assign dbus.adr   = adr;
   assign dbus.dat_w = dat;
   assign dbus.sel   = '1;
   assign dbus.we    = we_r;
   assign dbus.cyc   = cyc;
   assign dbus.stb   = cyc;

endmodule

`default_nettype wire

// ==== source/bs_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module bs_regfile (
   input  wire        clk,
   input  wire        i_rs_en,
   input  wire [4:0]  i_rs1_addr,
   input  wire [4:0]  i_rs2_addr,
   input  wire        i_rd_en,
   input  wire [4:0]  i_rd_addr,
   input  wire        i_rd,
   output logic       o_rs1,
   output logic       o_rs2
);

   logic [31:0] regs [1:31];

   // x0 has no storage and reads as zero
   assign o_rs1 = (i_rs1_addr == 5'd0) ? 1'b0 : regs[i_rs1_addr][0];
   assign o_rs2 = (i_rs2_addr == 5'd0) ? 1'b0 : regs[i_rs2_addr][0];

   for (genvar i = 1; i < 32; i++) begin : g_reg
      always_ff @(posedge clk) begin
         if (i_rd_en && (i_rd_addr == 5'(i))) begin
            regs[i] <= {i_rd, regs[i][31:1]};
         end else if (i_rs_en && ((i_rs1_addr == 5'(i)) || (i_rs2_addr == 5'(i)))) begin
            // rotate so the word is intact after 32 cycles
            regs[i] <= {regs[i][0], regs[i][31:1]};
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/bs_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module bs_alu (
   input  wire                  clk,
   input  wire                  i_en,
   input  wire                  i_init,
   input  rv_isa_pkg::alu_op_t  i_op,
   input  wire                  i_rs1,
   input  wire                  i_op_b,
   output logic                 o_rd,
   output logic                 o_cmp
);
   import rv_isa_pkg::*;

   logic carry;
   logic eq;
   logic lt_u;
   logic lt_s;
   logic sub;
   logic b_eff;
   logic cin;
   logic sum;
   logic eq_in;
   logic lt_in;
   logic diff;

   assign sub   = (i_op == ALU_SUB) | (i_op == ALU_SLT) | (i_op == ALU_SLTU);
   assign b_eff = i_op_b ^ sub;
   assign cin   = i_init ? sub : carry;
   assign sum   = i_rs1 ^ b_eff ^ cin;
   assign diff  = i_rs1 ^ i_op_b;
   assign eq_in = i_init | eq;
   assign lt_in = i_init ? 1'b0 : lt_u;

   // equality including the current bit, valid on the last cycle
   assign o_cmp = eq_in & ~diff;

   always_comb begin
      case (i_op)
         ALU_AND:  o_rd = i_rs1 & i_op_b;
         ALU_OR:   o_rd = i_rs1 | i_op_b;
         ALU_XOR:  o_rd = diff;
         // flag from the previous pass lands in bit 0
         ALU_SLT:  o_rd = i_init & lt_s;
         ALU_SLTU: o_rd = i_init & lt_u;
         default:  o_rd = sum;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_en) begin
         carry <= (i_rs1 & b_eff) | (cin & (i_rs1 ^ b_eff));
         eq    <= o_cmp;
         // lower bits decide unless this bit differs; msb flips the rule when signed
         lt_u  <= diff ? i_op_b : lt_in;
         lt_s  <= diff ? i_rs1 : lt_in;
      end
   end

endmodule

`default_nettype wire

// ==== source/bs_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module bs_ctrl #(
   parameter logic [31:0] RESET_PC = 32'd0
) (
   input  wire    clk,
   input  wire    i_rst_n,
   input  wire    i_en,
   input  wire    i_jump,
   input  wire    i_offset,
   input  wire    i_fetch,
   output logic   o_link_rd,
   output logic   o_cnt_done,
   wb_if.master   ibus
);

   logic [31:0] pc;
   logic [4:0]  cnt;
   logic        carry;
   logic        link_carry;
   logic        four_bit;
   logic        add_bit;
   logic        cin;
   logic        lcin;
   logic        pc_sum;
   logic        cyc;

   // constant 4 is a single one at bit 2
   assign four_bit = (cnt == 5'd2);
   assign add_bit  = i_jump ? i_offset : four_bit;
   assign cin      = (cnt == 5'd0) ? 1'b0 : carry;
   assign lcin     = (cnt == 5'd0) ? 1'b0 : link_carry;
   assign pc_sum   = pc[0] ^ add_bit ^ cin;

   assign o_link_rd  = pc[0] ^ four_bit ^ lcin;
   assign o_cnt_done = i_en & (cnt == 5'd31);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc         <= RESET_PC;
         cnt        <= 5'd0;
         carry      <= 1'b0;
         link_carry <= 1'b0;
         cyc        <= 1'b0;
      end else begin
         if (i_en) begin
            cnt        <= cnt + 5'd1;
            pc         <= {pc_sum, pc[31:1]};
            carry      <= (pc[0] & add_bit) | (cin & (pc[0] ^ add_bit));
            link_carry <= (pc[0] & four_bit) | (lcin & (pc[0] ^ four_bit));
         end
         if (cyc & ibus.ack) begin
            cyc <= 1'b0;
         end else if (i_fetch) begin
            cyc <= 1'b1;
         end
      end
   end

   assign ibus.adr   = pc;
   assign ibus.dat_w = '0;
   assign ibus.sel   = '1;
   assign ibus.we    = 1'b0;
   assign ibus.cyc   = cyc;
   assign ibus.stb   = cyc;

endmodule

`default_nettype wire

// ==== source/bs_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module bs_decode (
   input  wire                   clk,
   input  wire                   i_rst_n,
   input  wb_bus_pkg::wb_dat_t   i_insn,
   input  wire                   i_insn_vld,
   input  wire                   i_cnt_done,
   input  wire                   i_cmp,
   input  wire                   i_mem_done,
   output logic                  o_ctrl_en,
   output logic                  o_jump,
   output rv_isa_pkg::alu_op_t   o_alu_op,
   output logic                  o_alu_init,
   output logic                  o_rs_en,
   output logic                  o_rd_en,
   output logic [4:0]            o_rs1_addr,
   output logic [4:0]            o_rs2_addr,
   output logic [4:0]            o_rd_addr,
   output logic                  o_mem_en,
   output logic                  o_mem_we,
   output logic                  o_imm,
   output rv_isa_pkg::rd_src_t   o_rd_src,
   output rv_isa_pkg::opb_src_t  o_opb_src,
   output logic                  o_fetch
);
   import rv_isa_pkg::*;

   typedef enum logic [2:0] {S_FETCH, S_DECODE, S_EXEC, S_MEM, S_PHASE2} state_t;

   state_t      state;
   logic [31:0] insn;
   logic [31:0] imm_sr;
   logic [31:0] imm_new;
   logic        taken;
   logic        first;
   opcode_t     opc;
   opcode_t     new_opc;
   logic [2:0]  funct3;
   logic        is_op, is_slt, is_load, is_store, is_branch, is_jal, is_lui;
   logic        exec, ph2, imm_use;

   assign opc     = opcode_t'(insn[6:0]);
   assign new_opc = opcode_t'(i_insn[6:0]);
   assign funct3  = insn[14:12];

   assign is_op     = (opc == OPC_OP);
   assign is_slt    = is_op & ((funct3 == F3_SLT) | (funct3 == F3_SLTU));
   assign is_load   = (opc == OPC_LOAD);
   assign is_store  = (opc == OPC_STORE);
   assign is_branch = (opc == OPC_BRANCH);
   assign is_jal    = (opc == OPC_JAL);
   assign is_lui    = (opc == OPC_LUI);

   // sign-extended immediate of the incoming instruction
   always_comb begin
      case (new_opc)
         OPC_STORE:  imm_new = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
         OPC_BRANCH: imm_new = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25],
                                i_insn[11:8], 1'b0};
         OPC_LUI:    imm_new = {i_insn[31:12], 12'b0};
         OPC_JAL:    imm_new = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20],
                                i_insn[30:21], 1'b0};
         default:    imm_new = {{20{i_insn[31]}}, i_insn[31:20]};
      endcase
   end

   always_comb begin
      o_alu_op = ALU_ADD;
      if (is_branch) begin
         o_alu_op = ALU_SUB;
      end else if (is_op | (opc == OPC_OP_IMM)) begin
         case (funct3)
            F3_ADD:  o_alu_op = (is_op & insn[30]) ? ALU_SUB : ALU_ADD;
            F3_SLT:  o_alu_op = ALU_SLT;
            F3_SLTU: o_alu_op = ALU_SLTU;
            F3_XOR:  o_alu_op = ALU_XOR;
            F3_OR:   o_alu_op = ALU_OR;
            F3_AND:  o_alu_op = ALU_AND;
            default: o_alu_op = ALU_ADD;
         endcase
      end
   end

   assign exec = (state == S_EXEC);
   assign ph2  = (state == S_PHASE2);

   // branches consume their offset only in the second pass, other phases add zero
   assign imm_use = exec ? ~is_branch : (ph2 & is_branch);
   assign o_imm   = imm_use & imm_sr[0];

   assign o_ctrl_en  = exec | ph2;
   assign o_rs_en    = o_ctrl_en;
   assign o_alu_init = first & o_ctrl_en;
   assign o_jump     = exec ? (is_jal | is_branch) : (~is_branch | taken);
   assign o_rd_en    = exec ? ((opc == OPC_OP_IMM) | (is_op & ~is_slt) | is_lui | is_jal)
                            : (ph2 & (is_load | is_slt));
   assign o_mem_en   = (state == S_MEM);
   assign o_mem_we   = (is_store & (ph2 | o_mem_en)) | (is_load & ph2);
   assign o_fetch    = (state == S_FETCH);
   assign o_rs1_addr = insn[19:15];
   assign o_rs2_addr = insn[24:20];
   assign o_rd_addr  = insn[11:7];
   assign o_opb_src  = (is_op | is_branch) ? OPB_SRC_RS2 : OPB_SRC_IMM;
   assign o_rd_src   = is_lui  ? RD_SRC_IMM  :
                       is_jal  ? RD_SRC_CTRL :
                       is_load ? RD_SRC_MEM  : RD_SRC_ALU;

   always_ff @(posedge clk) begin
      if (i_insn_vld) begin
         insn   <= i_insn;
         imm_sr <= imm_new;
      end else if (imm_use) begin
         imm_sr <= {imm_sr[31], imm_sr[31:1]};
      end
      if (exec & i_cnt_done & is_branch) begin
         taken <= (funct3 == F3_BNE) ? ~i_cmp : i_cmp;
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state <= S_FETCH;
         first <= 1'b0;
      end else begin
         if (o_ctrl_en) begin
            first <= 1'b0;
         end
         case (state)
            S_FETCH: if (i_insn_vld) state <= S_DECODE;
            S_DECODE: begin
               state <= S_EXEC;
               first <= 1'b1;
            end
            S_EXEC: if (i_cnt_done) begin
               if (is_load) begin
                  state <= S_MEM;
               end else if (is_store | is_branch | is_slt) begin
                  state <= S_PHASE2;
                  first <= 1'b1;
               end else begin
                  state <= S_FETCH;
               end
            end
            S_MEM: if (i_mem_done) begin
               state <= is_load ? S_PHASE2 : S_FETCH;
               first <= 1'b1;
            end
            S_PHASE2: if (i_cnt_done) state <= is_store ? S_MEM : S_FETCH;
            default: state <= S_FETCH;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== source/wb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface wb_if;
   import wb_bus_pkg::*;

   wb_adr_t adr;
   wb_dat_t dat_w;
   wb_dat_t dat_r;
   wb_sel_t sel;
   logic    we;
   logic    cyc;
   logic    stb;
   logic    ack;

   modport master (
      output adr, dat_w, sel, we, cyc, stb,
      input  dat_r, ack
   );

   modport slave (
      input  adr, dat_w, sel, we, cyc, stb,
      output dat_r, ack
   );

endinterface

`default_nettype wire

// ==== source/wb_bus_pkg.sv ====
`default_nettype none

package wb_bus_pkg;

   localparam int WB_AW = 32;
   localparam int WB_DW = 32;
   localparam int WB_SW = 4;

   typedef logic [WB_AW-1:0] wb_adr_t;
   typedef logic [WB_DW-1:0] wb_dat_t;
   typedef logic [WB_SW-1:0] wb_sel_t;

endpackage

`default_nettype wire

// ==== source/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_LUI    = 7'b0110111,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111
   } opcode_t;

   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;
   localparam logic [2:0] F3_BNE  = 3'b001;

   // write-back bit source
   typedef enum logic [1:0] {
      RD_SRC_CTRL = 2'd0,
      RD_SRC_ALU  = 2'd1,
      RD_SRC_IMM  = 2'd2,
      RD_SRC_MEM  = 2'd3
   } rd_src_t;

   typedef enum logic {OPB_SRC_IMM = 1'b0, OPB_SRC_RS2 = 1'b1} opb_src_t;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
   } alu_op_t;

endpackage

`default_nettype wire
